//--- list.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_sram.sv
verilog/icache_tag_array.sv
verilog/icache_refill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
verification/tb_clk_gen.sv
verification/icache_chk.sv
verification/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the icache testbench with verilator and runs it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module icache_tb -f list.f -o icache_sim; then
  echo "verilator build failed"
  exit 1
fi

# assertion errors keep running so the testbench can see them and stop
if ! ./obj_dir/icache_sim +verilator+error+limit+100; then
  echo "simulation failed"
  exit 1
fi

echo "simulation finished cleanly"
exit 0

//--- verification/icache_tb.sv
// -------------------------------------------------------------------
// icache testbench: directed and random fetches against a cache model
// a bus memory answers every burst with address-derived data
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int n_rand     = 300;                      // random fetches
  localparam int n_dir      = 20;                       // directed steps and reset
  localparam int max_cycles = (n_rand + n_dir) * 40;

  logic     clk_i;
  logic     rst_ni;
  logic     req_i;
  addr_t    addr_i;
  logic     flush_i;
  logic     ack_o;
  cpu_rsp_t rsp_o;
  logic     bus_stb_o;
  addr_t    bus_adr_o;
  bus_rsp_t bus_rsp;

  integer   seed;
  int       cyc = 0;
  int       beat_end_cyc = 0;                           // last or error beat

  // cache model, one entry per set and way
  tag_t     m_tag   [`ICACHE_SETS][`ICACHE_WAYS];
  logic     m_valid [`ICACHE_SETS][`ICACHE_WAYS];
  int       m_ptr   [`ICACHE_SETS];                     // fifo victim

  tb_clk_gen #(
    .period_ns  (100),
    .rst_cycles (4)
  ) u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  icache_top u_icache_top (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .addr_i    (addr_i),
    .flush_i   (flush_i),
    .ack_o     (ack_o),
    .rsp_o     (rsp_o),
    .bus_stb_o (bus_stb_o),
    .bus_adr_o (bus_adr_o),
    .bus_rsp_i (bus_rsp)
  );

  // ------------------------------------------------------------------
  // memory contents and address helpers
  // ------------------------------------------------------------------
  function automatic word_t mem_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic in_err_range(input addr_t a);
    return a[31:8] == 24'h00_000e;                      // 0x0e00 to 0x0eff
  endfunction

  // few tags over four sets so lines get reused and evicted
  function automatic addr_t rand_addr();
    logic [31:0] r;
    tag_t        tag;
    r   = $random(seed);
    tag = (r[2:0] == 3'd7) ? tag_t'(24'h00_000e) : tag_t'(24'h00_0010 + r[4:3]);
    return {tag, 2'b00, r[9:8], r[15:12]};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error: %s is %h, expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // ------------------------------------------------------------------
  // bus slave: random waits, wrap order from the critical word
  // ------------------------------------------------------------------
  task automatic serve_burst(input addr_t adr);
    addr_t beat_adr;
    logic  bad;
    int    n;
    idle_cycles($unsigned($random(seed)) % 4);
    @(posedge clk_i);
    #1;
    bus_rsp.stb_ack = 1'b1;
    @(posedge clk_i);
    #1;
    bus_rsp.stb_ack = 1'b0;
    for (n = 0; n < `ICACHE_BEATS; n++)
    begin
      idle_cycles($unsigned($random(seed)) % 4);
      beat_adr     = {adr[31:4], adr[3:2] + 2'(n), 2'b00};
      bad          = in_err_range(adr) && n == 1;     // second beat fails
      bus_rsp.adro = beat_adr;
      bus_rsp.q    = mem_word(beat_adr);
      bus_rsp.ack  = !bad;
      bus_rsp.err  = bad;
      beat_end_cyc = cyc;
      @(posedge clk_i);
      #1;
      bus_rsp.ack  = 1'b0;
      bus_rsp.err  = 1'b0;
      if (bad)
        break;
    end
  endtask

  initial
  begin : bus_model
    forever
    begin
      @(negedge clk_i);
      if (bus_stb_o === 1'b1)
        serve_burst(bus_adr_o);
    end
  end

  // ------------------------------------------------------------------
  // cpu side
  // ------------------------------------------------------------------
  task automatic access(input addr_t a, input int exp_hit);
    addr_fields_t f;
    addr_t        wa;
    logic         hit_pred;
    logic         exp_err;
    int           w;
    int           way;
    f        = a;
    wa       = {a[31:2], 2'b00};
    hit_pred = 1'b0;
    for (w = 0; w < `ICACHE_WAYS; w++)
      if (m_valid[f.idx][w] && m_tag[f.idx][w] == f.tag)
        hit_pred = 1'b1;
    if (exp_hit >= 0)
      check_eq("model hit", 32'(hit_pred), exp_hit);  // directed step sanity
    exp_err = !hit_pred && in_err_range(a);
    @(posedge clk_i);
    #1;
    req_i  = 1'b1;
    addr_i = a;
    @(posedge clk_i);
    #1;
    req_i  = 1'b0;
    @(negedge clk_i);
    if (hit_pred)
    begin
      check_eq("ack_o", 32'(ack_o), 1);
    end
    else
    begin
      check_eq("ack_o", 32'(ack_o), 0);
      @(negedge clk_i);
      check_eq("bus_stb_o", 32'(bus_stb_o), 1);
      check_eq("bus_adr_o", bus_adr_o, wa);
      while (ack_o !== 1'b1)
        @(negedge clk_i);
      check_eq("ack_o cycle", cyc, beat_end_cyc + 2);  // two after last beat
    end
    check_eq("rsp_o.err", 32'(rsp_o.err), 32'(exp_err));
    if (!exp_err)
      check_eq("rsp_o.data", rsp_o.data, mem_word(wa));
    if (hit_pred)
    begin
      @(negedge clk_i);
      check_eq("bus_stb_o", 32'(bus_stb_o), 0);       // no refill behind a hit
    end
    if (!hit_pred && !exp_err)
    begin
      way                  = m_ptr[f.idx];
      m_tag[f.idx][way]    = f.tag;
      m_valid[f.idx][way]  = 1'b1;
      m_ptr[f.idx]         = (way + 1) % `ICACHE_WAYS;
    end
  endtask

  task automatic drop_all();
    int s;
    int w;
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    for (s = 0; s < `ICACHE_SETS; s++)
      for (w = 0; w < `ICACHE_WAYS; w++)
        m_valid[s][w] = 1'b0;                         // fifo pointers stay
  endtask

  // cycle count, timeout and assertion watch
  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
    if (cyc > max_cycles)
    begin
      $display("timeout after %0d cycles, the DUT stopped answering", cyc);
      $display("Test FAILED");
      $fatal(1);
    end
    else if (u_icache_top.u_chk.any_fail)
    begin
      $display("a bound protocol assertion failed");
      $display("Test FAILED");
      $fatal(1);
    end
  end

  initial
  begin : main
    int s;
    int w;
    int n;
    seed    = 32'h7910_51a2;
    req_i   = 1'b0;
    addr_i  = '0;
    flush_i = 1'b0;
    bus_rsp = '0;
    for (s = 0; s < `ICACHE_SETS; s++)
    begin
      m_ptr[s] = 0;
      for (w = 0; w < `ICACHE_WAYS; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end
    @(posedge rst_ni);
    @(negedge clk_i);
    check_eq("ack_o", 32'(ack_o), 0);
    check_eq("bus_stb_o", 32'(bus_stb_o), 0);

    access(32'h0000_1004, 0);                         // cold miss
    access(32'h0000_100c, 1);                         // same block hits
    // three blocks into set 5
    access(32'h0000_2050, 0);
    access(32'h0000_2150, 0);
    access(32'h0000_2258, 0);                         // evicts 0x2050
    access(32'h0000_2054, 0);                         // oldest gone, evicts 0x2150
    access(32'h0000_225c, 1);
    access(32'h0000_2158, 0);
    // flush
    access(32'h0000_1000, 1);
    drop_all();
    access(32'h0000_1008, 0);
    // bus error, retry misses again
    access(32'h0000_0e34, 0);
    access(32'h0000_0e30, 0);

    for (n = 0; n < n_rand; n++)
    begin
      if ($unsigned($random(seed)) % 32 == 0)
        drop_all();
      access(rand_addr(), -1);
    end

    @(negedge clk_i);
    if (!u_icache_top.u_chk.any_fail)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("a bound protocol assertion failed at the end of the run");
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule

//--- verification/icache_chk.sv
// -------------------------------------------------------------------
// cpu and bus protocol assertions, bound into the icache top level
// -------------------------------------------------------------------
`timescale 1ns/1ps

module icache_chk
  import icache_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     req_i,
  input logic     flush_i,
  input logic     ack_o,
  input logic     bus_stb_o,
  input addr_t    bus_adr_o,
  input bus_rsp_t bus_rsp_i
);

  logic pending_q;          // request taken, ack not seen yet
  bit   busy_bad = 1'b0;
  bit   hold_bad = 1'b0;
  bit   ack_bad  = 1'b0;
  logic any_fail;           // sticky, watched from the testbench

  assign any_fail = busy_bad | hold_bad | ack_bad;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pending_q <= 1'b0;
    else if (req_i)
      pending_q <= 1'b1;    // also a new one on the ack cycle
    else if (ack_o)
      pending_q <= 1'b0;
  end

  // cpu side: one request at a time
  a_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pending_q && !ack_o |-> !req_i && !flush_i)
    else
    begin
      $error("request or flush while a request is pending");
      busy_bad = 1'b1;
    end

  // bus strobe holds its address until accepted
  a_adr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bus_stb_o && !bus_rsp_i.stb_ack |=> bus_stb_o && $stable(bus_adr_o))
    else
    begin
      $error("bus address changed or strobe dropped before stb_ack");
      hold_bad = 1'b1;
    end

  a_ack_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ack_o |-> pending_q)
    else
    begin
      $error("ack without an outstanding request");
      ack_bad = 1'b1;
    end

endmodule

bind icache_top icache_chk u_chk (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (req_i),
  .flush_i   (flush_i),
  .ack_o     (ack_o),
  .bus_stb_o (bus_stb_o),
  .bus_adr_o (bus_adr_o),
  .bus_rsp_i (bus_rsp_i)
);

//--- verification/tb_clk_gen.sv
// -------------------------------------------------------------------
// testbench clock and active-low reset
// -------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned period_ns  = 100,
  parameter int unsigned rst_cycles = 4
)
(
  output logic clk_o,
  output logic rst_no
);

  initial
  begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_no = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    #1 rst_no = 1'b1;   // release just after an edge
  end

endmodule

//--- verilog/icache_top.sv
// -------------------------------------------------------------------
// icache core: cpu lookup port, flush strobe, one refill bus master
// -------------------------------------------------------------------
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,       // one-cycle strobe
  input  addr_t    addr_i,
  input  logic     flush_i,     // only while idle
  output logic     ack_o,
  output cpu_rsp_t rsp_o,
  output logic     bus_stb_o,
  output addr_t    bus_adr_o,
  input  bus_rsp_t bus_rsp_i
);

  idx_t     lkp_idx;
  tag_t     lkp_tag;
  way_sel_t hit;
  way_sel_t victim;
  logic     fill;
  logic     refill_start;
  addr_t    refill_addr;
  logic     refill_done;
  logic     refill_err;
  block_t   line;

  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .addr_i         (addr_i),
    .hit_i          (hit),
    .victim_i       (victim),
    .lkp_idx_o      (lkp_idx),
    .lkp_tag_o      (lkp_tag),
    .fill_o         (fill),
    .refill_start_o (refill_start),
    .refill_addr_o  (refill_addr),
    .refill_done_i  (refill_done),
    .refill_err_i   (refill_err),
    .line_i         (line),
    .ack_o          (ack_o),
    .rsp_o          (rsp_o)
  );

  icache_tag_array u_tag_array (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .idx_i    (lkp_idx),
    .tag_i    (lkp_tag),
    .fill_i   (fill),
    .hit_o    (hit),
    .victim_o (victim)
  );

  icache_refill u_refill (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (refill_start),
    .addr_i    (refill_addr),
    .bus_stb_o (bus_stb_o),
    .bus_adr_o (bus_adr_o),
    .bus_rsp_i (bus_rsp_i),
    .done_o    (refill_done),
    .err_o     (refill_err),
    .line_o    (line)
  );

endmodule

//--- verilog/icache_ctrl.sv
// -------------------------------------------------------------------
// request fsm with the data rams: hit path, miss handoff, response
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  addr_t    addr_i,
  input  way_sel_t hit_i,
  input  way_sel_t victim_i,
  output idx_t     lkp_idx_o,        // to tag array
  output tag_t     lkp_tag_o,
  output logic     fill_o,
  output logic     refill_start_o,
  output addr_t    refill_addr_o,
  input  logic     refill_done_i,
  input  logic     refill_err_i,
  input  block_t   line_i,
  output logic     ack_o,
  output cpu_rsp_t rsp_o
);

  typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, DONE} state_e;

  state_e       state_q;
  addr_t        addr_q;              // request being served
  logic         err_q;               // refill ended in error
  logic         accept;
  addr_fields_t req_f;
  addr_fields_t held_f;
  block_t       way_blk [`ICACHE_WAYS];
  block_t       hit_blk;

  assign req_f  = addr_i;
  assign held_f = addr_q;

  assign ack_o  = (state_q == LOOKUP && |hit_i) || state_q == DONE;
  assign accept = req_i && (state_q == IDLE || ack_o);   // back-to-back on ack is fine

  // new request reads the arrays now, otherwise keep the held set
  assign lkp_idx_o = accept ? req_f.idx : held_f.idx;
  assign lkp_tag_o = accept ? req_f.tag : held_f.tag;

  assign refill_start_o = (state_q == LOOKUP) && !(|hit_i);
  assign refill_addr_o  = addr_q;
  assign fill_o         = refill_done_i;   // never on error

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
          if (accept)
            state_q <= LOOKUP;
        LOOKUP:
          if (!(|hit_i))
            state_q <= REFILL;
          else if (!accept)
            state_q <= IDLE;
        REFILL:
          if (refill_done_i || refill_err_i)
          begin
            state_q <= DONE;
            err_q   <= refill_err_i;
          end
        DONE:
          state_q <= accept ? LOOKUP : IDLE;   // also the idle slot after a fill
        default:
          state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      addr_q <= addr_i;
  end

  // -----------------------------------------------------------------
  // data rams, line written into the victim on refill done
  // -----------------------------------------------------------------
  for (genvar w = 0; w < `ICACHE_WAYS; w++)
  begin : g_way
    icache_sram #(
      .word_t (block_t),
      .depth  (`ICACHE_SETS)
    ) u_data_ram (
      .clk_i   (clk_i),
      .addr_i  (lkp_idx_o),
      .we_i    (refill_done_i & victim_i[w]),
      .wdata_i (line_i),
      .rdata_o (way_blk[w])
    );
  end

  // and-or way select, hit is one-hot
  always_comb
  begin
    hit_blk = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (hit_i[w])
        hit_blk = hit_blk | way_blk[w];
  end

  assign rsp_o.data = (state_q == DONE) ? line_i[held_f.word] : hit_blk[held_f.word];
  assign rsp_o.err  = (state_q == DONE) & err_q;

endmodule

//--- verilog/icache_refill.sv
// -------------------------------------------------------------------
// line refill over the bus: one wrapping burst, beats land by address
// start_i once per miss, then wait for done_o or err_o
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_refill
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,     // miss, fetch the line holding addr_i
  input  addr_t    addr_i,
  output logic     bus_stb_o,   // burst request
  output addr_t    bus_adr_o,   // critical word address
  input  bus_rsp_t bus_rsp_i,
  output logic     done_o,      // line complete
  output logic     err_o,       // burst failed, line unusable
  output block_t   line_o
);

  typedef enum logic [1:0] {IDLE, WAIT, BURST} state_e;

  state_e       state_q;
  addr_t        adr_q;       // held for the whole strobe phase
  boff_t        cnt_q;       // beats taken so far
  block_t       line_q;
  logic         done_q;
  logic         err_q;
  addr_fields_t start_f;
  addr_fields_t adro_f;
  logic         last_beat;

  // word aligned start address, bus wraps from there
  always_comb
  begin
    start_f          = addr_i;
    start_f.byte_off = '0;
  end

  assign adro_f    = bus_rsp_i.adro;
  assign last_beat = bus_rsp_i.ack & (cnt_q == boff_t'(`ICACHE_BEATS - 1));

  // -----------------------------------------------------------------
  // burst fsm
  // -----------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;   // both are single-cycle
      err_q  <= 1'b0;
      case (state_q)
        IDLE:
          if (start_i)
          begin
            state_q <= WAIT;
            cnt_q   <= '0;
          end
        WAIT:
          if (bus_rsp_i.stb_ack)
            state_q <= BURST;
        BURST:
          if (bus_rsp_i.err)
          begin
            state_q <= IDLE;   // abort, whatever beats came are dropped
            err_q   <= 1'b1;
          end
          else if (bus_rsp_i.ack)
          begin
            cnt_q <= cnt_q + 1'b1;
            if (last_beat)
            begin
              state_q <= IDLE;
              done_q  <= 1'b1;
            end
          end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // address and line buffer, payload only
  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && start_i)
      adr_q <= start_f;
    if (state_q == BURST && bus_rsp_i.ack && !bus_rsp_i.err)
      line_q[adro_f.word] <= bus_rsp_i.q;   // slot from beat address, not count
  end

  assign bus_stb_o = (state_q == WAIT);
  assign bus_adr_o = adr_q;
  assign done_o    = done_q;
  assign err_o     = err_q;
  assign line_o    = line_q;   // stable until the next start

endmodule

//--- verilog/icache_tag_array.sv
// -------------------------------------------------------------------
// tag rams per way, valid flops, hit compare and fifo victim per set
// hit_o and victim_o refer to the index seen on the previous cycle
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tag_array
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,   // drop every line
  input  idx_t     idx_i,     // lookup or fill set
  input  tag_t     tag_i,     // lookup or fill tag
  input  logic     fill_i,    // write tag_i into victim way
  output way_sel_t hit_o,
  output way_sel_t victim_o
);

  localparam int unsigned ptr_bits = ($clog2(`ICACHE_WAYS) > 0) ? $clog2(`ICACHE_WAYS) : 1;

  idx_t idx_q;                                    // lookup set, aligned with ram output
  tag_t tag_q;                                    // lookup tag, same cycle
  tag_t way_tag [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;
  logic [ptr_bits-1:0] ptr_q [`ICACHE_SETS];      // next way to replace

  always_ff @(posedge clk_i)
  begin
    idx_q <= idx_i;
    tag_q <= tag_i;
  end

  // -----------------------------------------------------------------
  // per-way storage and compare
  // -----------------------------------------------------------------
  for (genvar w = 0; w < `ICACHE_WAYS; w++)
  begin : g_way
    icache_sram #(
      .word_t (tag_t),
      .depth  (`ICACHE_SETS)
    ) u_tag_ram (
      .clk_i   (clk_i),
      .addr_i  (idx_i),
      .we_i    (fill_i & victim_o[w]),   // only the victim way takes the tag
      .wdata_i (tag_i),
      .rdata_o (way_tag[w])
    );

    assign hit_o[w] = valid_q[w][idx_q] & (way_tag[w] == tag_q);
  end

  // valid bits in flops so flush clears all sets at once
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
    end
    else if (flush_i)
    begin
      valid_q <= '0;
    end
    else if (fill_i)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
        if (victim_o[w])
          valid_q[w][idx_i] <= 1'b1;
    end
  end

  // -----------------------------------------------------------------
  // fifo replacement, pointer steps on every fill of its set
  // -----------------------------------------------------------------
  assign victim_o = way_sel_t'(1) << ptr_q[idx_q];   // idx_q == idx_i while filling

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
        ptr_q[s] <= '0;
    end
    else if (fill_i)
    begin
      ptr_q[idx_i] <= (ptr_q[idx_i] == ptr_bits'(`ICACHE_WAYS - 1)) ? '0
                                                                     : ptr_q[idx_i] + 1'b1;
    end
  end

endmodule

//--- verilog/icache_sram.sv
// -------------------------------------------------------------------
// single-port ram, registered read, payload type set per instance
// -------------------------------------------------------------------
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_sram
  import icache_pkg::*;
#(
  parameter type         word_t = logic [`ICACHE_WORD_BITS-1:0],  // tag or line
  parameter int unsigned depth  = `ICACHE_SETS
)
(
  input  logic  clk_i,
  input  idx_t  addr_i,
  input  logic  we_i,
  input  word_t wdata_i,
  output word_t rdata_o
);

  word_t mem_q [depth];   // no reset, contents qualified by valid flops

  // write wins, read data stale on a write cycle
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem_q[addr_i] <= wdata_i;
    end
    else
    begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

//--- verilog/icache_pkg.sv
// -------------------------------------------------------------------
// icache types: address fields, line payload, cpu and bus port structs
// -------------------------------------------------------------------
`include "icache_settings.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_BITS-1:0]      addr_t;
  typedef logic [`ICACHE_WORD_BITS-1:0]      word_t;
  typedef logic [`ICACHE_IDX_BITS-1:0]       idx_t;
  typedef logic [`ICACHE_TAG_BITS-1:0]       tag_t;
  typedef logic [$clog2(`ICACHE_BEATS)-1:0]  boff_t;   // word slot in a line
  typedef word_t [`ICACHE_BEATS-1:0]         block_t;  // whole line, slot 0 lowest
  typedef logic [`ICACHE_WAYS-1:0]           way_sel_t; // one-hot

  // address split, msb first
  typedef struct packed {
    tag_t  tag;
    idx_t  idx;
    boff_t word;
    logic [`ICACHE_OFF_BITS-$clog2(`ICACHE_BEATS)-1:0] byte_off;
  } addr_fields_t;

  // cpu response, valid with ack
  typedef struct packed {
    word_t data;
    logic  err;   // refill hit a bus error
  } cpu_rsp_t;

  // everything the bus drives back to us
  typedef struct packed {
    logic  stb_ack;  // burst accepted
    logic  ack;      // beat valid
    logic  err;      // beat failed, burst ends
    addr_t adro;     // word address of this beat
    word_t q;        // beat data
  } bus_rsp_t;

endpackage

//--- verilog/icache_settings.svh
// -------------------------------------------------------------------
// icache geometry, include wherever a width or a count is needed
// -------------------------------------------------------------------
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// base sizes
`define ICACHE_ADDR_BITS   32            // byte address
`define ICACHE_WORD_BITS   32            // one cpu word
`define ICACHE_BLOCK_BYTES 16            // one cache line
`define ICACHE_WAYS        2             // associativity
`define ICACHE_SETS        16            // sets per way

// derived, keep in sync with the base sizes only through these
`define ICACHE_OFF_BITS    ($clog2(`ICACHE_BLOCK_BYTES))
`define ICACHE_IDX_BITS    ($clog2(`ICACHE_SETS))
`define ICACHE_TAG_BITS    (`ICACHE_ADDR_BITS - `ICACHE_OFF_BITS - `ICACHE_IDX_BITS)
`define ICACHE_BEATS       (`ICACHE_BLOCK_BYTES * 8 / `ICACHE_WORD_BITS)

`endif
